// ==== all.f ====
+incdir+logic
logic/mem_pkg.sv
logic/dmem_byte_lane.sv
logic/mem_access_ctrl.sv
logic/load_align_wb.sv
logic/mem_stage.sv
verification/mem_stage_sva.sv
verification/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_pkg.sv
      - logic/dmem_byte_lane.sv
      - logic/mem_access_ctrl.sv
      - logic/load_align_wb.sv
      - logic/mem_stage.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verification/mem_stage_sva.sv
      - verification/mem_stage_tb.sv

// ==== verification/mem_stage_tb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage_tb;

    import mem_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int FILL_CYCLES  = 16;
    localparam int SWEEP_CYCLES = 40;
    localparam int GUARD_CYCLES = 40;
    localparam int RAND_CYCLES  = 400;
    localparam int TAIL_CYCLES  = 3;
    localparam int STIM_CYCLES  = RESET_CYCLES + FILL_CYCLES + SWEEP_CYCLES
                                + GUARD_CYCLES + RAND_CYCLES + TAIL_CYCLES;
    localparam int CYCLE_LIMIT  = 4 * STIM_CYCLES + 100;

    logic        clk;
    logic        rst;
    logic        memwb_en;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    data_t       fwd_data;
    reg_addr_t   fwd_addr;
    logic        fwd_wr;
    logic [31:0] rng_state;
    int          cycle_cnt = 0;

    mem_stage uut (
        .clk        (clk),
        .rst        (rst),
        .memwb_en_i (memwb_en),
        .ex_mem_i   (ex_mem),
        .mem_wb_o   (mem_wb),
        .fwd_data_o (fwd_data),
        .fwd_addr_o (fwd_addr),
        .fwd_wr_o   (fwd_wr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mem_type_t valid_type(input int idx);
        case (idx)
            0:       return `MEM_BYTE;
            1:       return `MEM_HWORD;
            2:       return `MEM_WORD;
            3:       return `MEM_BYTE_U;
            default: return `MEM_HWORD_U;
        endcase
    endfunction

    function automatic mem_type_t invalid_type(input int idx);
        case (idx)
            0:       return 3'd3;
            1:       return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    // accesses stay in words 0 to 15, upper address bits are noise.
    function automatic ex_mem_t make_record(input logic rd, input logic wr, input mem_type_t t,
                                            input logic [3:0] word, input logic [1:0] off);
        ex_mem_t     r;
        logic [31:0] upper;
        logic [31:0] flags;
        upper      = rand_word();
        flags      = rand_word();
        r          = '0;
        r.aluout   = {upper[31:12], 6'd0, word, off};
        r.pc2reg   = rand_word();
        r.rd_src   = flags[0];
        r.dm_data  = rand_word();
        r.rd_addr  = flags[5:1];
        r.reg_wr   = flags[6];
        r.dm_rd    = rd;
        r.dm_wr    = wr;
        r.dm2reg   = rd;
        r.datatype = t;
        return r;
    endfunction

    task automatic drive(input ex_mem_t rec, input logic en);
        @(posedge clk);
        #1;
        ex_mem   = rec;
        memwb_en = en;
    endtask

    task automatic report_failure(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    initial begin
        mem_type_t   t;
        logic [31:0] r;
        logic [3:0]  word;
        rng_state = 32'h51cf_efa6;
        rst       = 1'b0;
        memwb_en  = 1'b0;
        ex_mem    = '0;
        #1;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // word stores so every byte of the region is known.
        for (int w = 0; w < FILL_CYCLES; w++) begin
            drive(make_record(1'b0, 1'b1, `MEM_WORD, 4'(w), 2'd0), 1'b1);
        end

        // every valid type at every offset, store then load back.
        for (int k = 0; k < SWEEP_CYCLES / 2; k++) begin
            t    = valid_type(k / 4);
            r    = rand_word();
            word = r[3:0];
            drive(make_record(1'b0, 1'b1, t, word, 2'(k % 4)), 1'b1);
            drive(make_record(1'b1, 1'b0, t, word, 2'(k % 4)), 1'b1);
        end

        // stores that must leave memory alone, each read back as a word.
        for (int k = 0; k < GUARD_CYCLES / 2; k++) begin
            r    = rand_word();
            word = r[3:0];
            if (k < 12) begin
                drive(make_record(1'b0, 1'b1, invalid_type(k % 3), word, r[5:4]), 1'b1);
            end else begin
                drive(make_record(1'b0, 1'b0, valid_type(k % 5), word, r[5:4]), 1'b1);
            end
            drive(make_record(1'b1, 1'b0, `MEM_WORD, word, 2'd0), 1'b1);
        end

        // random mix with all eight type codes and stalls.
        for (int k = 0; k < RAND_CYCLES; k++) begin
            r = rand_word();
            t = mem_type_t'(r[2:0]);
            drive(make_record(r[3] & ~r[4], r[4], t, r[8:5], r[10:9]), r[12:11] != 2'b00);
        end

        drive('0, 1'b1);
        drive('0, 1'b1);
        @(posedge clk);
        #1;
        if (uut.u_sva.fail_cnt != 0) begin
            report_failure("checker assertions failed during the run");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (uut.u_sva.fail_cnt != 0) begin
            report_failure("a checker assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            report_failure("the run went past its cycle limit");
        end
    end

endmodule

// ==== verification/mem_stage_sva.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage_sva (
    input logic               clk,
    input logic               rst,
    input logic               memwb_en_i,
    input mem_pkg::ex_mem_t   ex_mem_i,
    input mem_pkg::mem_wb_t   mem_wb_o,
    input mem_pkg::data_t     fwd_data_o,
    input mem_pkg::reg_addr_t fwd_addr_o,
    input logic               fwd_wr_o
);

    import mem_pkg::*;

    localparam int NBYTES = 4 * (2 ** `DMEM_WORDS_LOG2);

    logic [7:0] shadow  [NBYTES];
    logic       written [NBYTES];
    int         fail_cnt = 0;
    word_idx_t  widx;
    logic [3:0] sel;
    logic [3:0] need;
    logic       all_known;
    logic [1:0] shift;
    data_t      rd_word;
    data_t      st_word;
    data_t      load_exp;
    mem_wb_t    exp_q;
    logic       chk_load_q;

    // lanes an access touches with 1 for selected.
    function automatic logic [3:0] lanes_for(input mem_type_t t, input logic [1:0] off);
        case (t)
            `MEM_BYTE, `MEM_BYTE_U:   return 4'b0001 << off;
            `MEM_HWORD, `MEM_HWORD_U: return (off == 2'd3) ? 4'b1000 : (4'b0011 << off);
            `MEM_WORD:                return 4'b1111;
            default:                  return 4'b0000;
        endcase
    endfunction

    // selected bytes packed from the lowest lane and then extended.
    function automatic data_t extract(input logic [3:0] s, input data_t word, input logic unsgn);
        data_t v;
        int    k;
        v = '0;
        k = 0;
        if (s == 4'b0000) begin
            return word;
        end
        for (int n = 0; n < 4; n++) begin
            if (s[n]) begin
                v[8*k +: 8] = word[8*n +: 8];
                k++;
            end
        end
        if (!unsgn) begin
            for (int b = 8 * k; b < 32; b++) begin
                v[b] = v[8*k-1];
            end
        end
        return v;
    endfunction

    always_comb begin
        widx      = ex_mem_i.aluout[`DMEM_WORDS_LOG2+1:2];
        sel       = lanes_for(ex_mem_i.datatype, ex_mem_i.aluout[1:0]);
        need      = (sel == 4'b0000) ? 4'b1111 : sel;
        all_known = 1'b1;
        for (int n = 0; n < 4; n++) begin
            rd_word[8*n +: 8] = shadow[{widx, 2'(n)}];
            if (need[n] && written[{widx, 2'(n)}] !== 1'b1) begin
                all_known = 1'b0;
            end
        end
        load_exp = extract(sel, rd_word, ex_mem_i.datatype[2]);
        shift    = (ex_mem_i.datatype == `MEM_WORD) ? 2'd0 : ex_mem_i.aluout[1:0];
        st_word  = ex_mem_i.dm_data << (8 * shift);
    end

    always_ff @(posedge clk) begin
        if (ex_mem_i.dm_wr) begin
            for (int n = 0; n < 4; n++) begin
                if (sel[n]) begin
                    shadow[{widx, 2'(n)}] <= st_word[8*n +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NBYTES; i++) begin
                written[i] <= 1'b0;
            end
        end else if (ex_mem_i.dm_wr) begin
            for (int n = 0; n < 4; n++) begin
                if (sel[n]) begin
                    written[{widx, 2'(n)}] <= 1'b1;
                end
            end
        end
    end

    // expected mem_wb_o under the same stall enable.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_q      <= '0;
            chk_load_q <= 1'b0;
        end else if (memwb_en_i) begin
            exp_q.rd_data <= ex_mem_i.rd_src ? ex_mem_i.pc2reg : ex_mem_i.aluout;
            exp_q.rd_addr <= ex_mem_i.rd_addr;
            exp_q.reg_wr  <= ex_mem_i.reg_wr;
            exp_q.dm_out  <= load_exp;
            exp_q.dm2reg  <= ex_mem_i.dm2reg;
            chk_load_q    <= ex_mem_i.dm_rd && all_known;
        end
    end

    a_reset_zero: assert property (@(posedge clk) (rst || $fell(rst)) |-> mem_wb_o == '0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: mem_wb_o got %h expected 0 at reset", $sampled(mem_wb_o));
        end

    a_fwd_data: assert property (@(posedge clk)
        fwd_data_o == (ex_mem_i.rd_src ? ex_mem_i.pc2reg : ex_mem_i.aluout))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: fwd_data_o got %h expected %h", $sampled(fwd_data_o),
                   $sampled(ex_mem_i.rd_src ? ex_mem_i.pc2reg : ex_mem_i.aluout));
        end

    a_fwd_ctrl: assert property (@(posedge clk)
        fwd_addr_o == ex_mem_i.rd_addr && fwd_wr_o == ex_mem_i.reg_wr)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: fwd_addr_o/fwd_wr_o got %h expected %h",
                   $sampled({fwd_addr_o, fwd_wr_o}),
                   $sampled({ex_mem_i.rd_addr, ex_mem_i.reg_wr}));
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        mem_wb_o.rd_data == exp_q.rd_data)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: mem_wb_o.rd_data got %h expected %h",
                   $sampled(mem_wb_o.rd_data), $sampled(exp_q.rd_data));
        end

    a_wb_ctrl: assert property (@(posedge clk) disable iff (rst)
        {mem_wb_o.rd_addr, mem_wb_o.reg_wr, mem_wb_o.dm2reg} ==
        {exp_q.rd_addr, exp_q.reg_wr, exp_q.dm2reg})
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: mem_wb_o rd_addr/reg_wr/dm2reg got %h expected %h",
                   $sampled({mem_wb_o.rd_addr, mem_wb_o.reg_wr, mem_wb_o.dm2reg}),
                   $sampled({exp_q.rd_addr, exp_q.reg_wr, exp_q.dm2reg}));
        end

    a_hold: assert property (@(posedge clk) disable iff (rst) !memwb_en_i |=> $stable(mem_wb_o))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: mem_wb_o changed to %h while the enable was low",
                   $sampled(mem_wb_o));
        end

    a_load: assert property (@(posedge clk) disable iff (rst)
        chk_load_q |-> mem_wb_o.dm_out == exp_q.dm_out)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error: mem_wb_o.dm_out got %h expected %h",
                   $sampled(mem_wb_o.dm_out), $sampled(exp_q.dm_out));
        end

endmodule

bind mem_stage mem_stage_sva u_sva (.*);

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               memwb_en_i,
    input  mem_pkg::ex_mem_t   ex_mem_i,
    output mem_pkg::mem_wb_t   mem_wb_o,
    output mem_pkg::data_t     fwd_data_o,
    output mem_pkg::reg_addr_t fwd_addr_o,
    output logic               fwd_wr_o
);

    import mem_pkg::*;

    lane_req_t [`LANES-1:0] lane_req;
    lane_mask_t             lane_mask;
    logic                   load_signed;
    data_t                  rd_bytes;

    mem_access_ctrl u_ctrl (
        .ex_mem_i      (ex_mem_i),
        .fwd_data_o    (fwd_data_o),
        .fwd_addr_o    (fwd_addr_o),
        .fwd_wr_o      (fwd_wr_o),
        .lane_mask_o   (lane_mask),
        .load_signed_o (load_signed),
        .lane_req_o    (lane_req)
    );

    // one byte-wide memory per lane.
    for (genvar g = 0; g < `LANES; g++) begin : g_lane
        dmem_byte_lane #(
            .WORDS_LOG2 (`DMEM_WORDS_LOG2)
        ) u_lane (
            .clk       (clk),
            .req_i     (lane_req[g]),
            .rd_byte_o (rd_bytes[8*g +: 8])
        );
    end

    load_align_wb u_wb (
        .clk           (clk),
        .rst           (rst),
        .memwb_en_i    (memwb_en_i),
        .ex_mem_i      (ex_mem_i),
        .fwd_data_i    (fwd_data_o),
        .lane_mask_i   (lane_mask),
        .load_signed_i (load_signed),
        .rd_bytes_i    (rd_bytes),
        .mem_wb_o      (mem_wb_o)
    );

endmodule

// ==== logic/load_align_wb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module load_align_wb (
    input  logic                clk,
    input  logic                rst,
    input  logic                memwb_en_i,
    input  mem_pkg::ex_mem_t    ex_mem_i,
    input  mem_pkg::data_t      fwd_data_i,
    input  mem_pkg::lane_mask_t lane_mask_i,
    input  logic                load_signed_i,
    input  mem_pkg::data_t      rd_bytes_i,
    output mem_pkg::mem_wb_t    mem_wb_o
);

    import mem_pkg::*;

    data_t                   gathered;
    data_t                   load_val;
    logic [$clog2(`LANES):0] n_sel;
    logic                    fill_bit;
    mem_wb_t                 mem_wb_d;

    // pack the selected lanes from the lowest up.
    always_comb begin
        gathered = '0;
        n_sel    = '0;
        for (int n = 0; n < `LANES; n++) begin
            if (!lane_mask_i[n]) begin
                gathered[8*n_sel +: 8] = rd_bytes_i[8*n +: 8];
                n_sel = n_sel + 1'b1;
            end
        end
    end

    always_comb begin
        load_val = gathered;
        fill_bit = 1'b0;
        if (n_sel == '0) begin
            // no lane selected, raw word passes through.
            load_val = rd_bytes_i;
        end else if (n_sel < `LANES) begin
            fill_bit = load_signed_i & gathered[8*n_sel-1];
            for (int b = 0; b < `DATA_BITS; b++) begin
                if (b >= 8*n_sel) begin
                    load_val[b] = fill_bit;
                end
            end
        end
    end

    always_comb begin
        mem_wb_d.rd_data = fwd_data_i;
        mem_wb_d.rd_addr = ex_mem_i.rd_addr;
        mem_wb_d.reg_wr  = ex_mem_i.reg_wr;
        mem_wb_d.dm_out  = load_val;
        mem_wb_d.dm2reg  = ex_mem_i.dm2reg;
    end

    // holds while the enable is low.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_o <= '0;
        end else if (memwb_en_i) begin
            mem_wb_o <= mem_wb_d;
        end
    end

endmodule

// ==== logic/mem_access_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_access_ctrl (
    input  mem_pkg::ex_mem_t                  ex_mem_i,
    output mem_pkg::data_t                    fwd_data_o,
    output mem_pkg::reg_addr_t                fwd_addr_o,
    output logic                              fwd_wr_o,
    output mem_pkg::lane_mask_t               lane_mask_o,
    output logic                              load_signed_o,
    output mem_pkg::lane_req_t [`LANES-1:0]   lane_req_o
);

    import mem_pkg::*;

    addr_t      eff_addr;
    logic [1:0] offset;
    mem_type_t  dtype;
    word_idx_t  word_idx;
    lane_mask_t byte_mask;
    lane_mask_t half_mask;
    lane_mask_t lane_mask;
    logic [1:0] wr_shift;
    data_t      wr_word;

    // forward path back to execute.
    assign fwd_data_o = ex_mem_i.rd_src ? ex_mem_i.pc2reg : ex_mem_i.aluout;
    assign fwd_addr_o = ex_mem_i.rd_addr;
    assign fwd_wr_o   = ex_mem_i.reg_wr;

    // address only reaches the lanes on real accesses.
    assign eff_addr = (ex_mem_i.dm_rd || ex_mem_i.dm_wr) ? addr_t'(ex_mem_i.aluout) : '0;
    assign offset   = eff_addr[1:0];
    assign word_idx = eff_addr[`DMEM_WORDS_LOG2+1:2];
    assign dtype    = ex_mem_i.datatype;

    always_comb begin
        byte_mask = ~(lane_mask_t'(1) << offset);
        // offset 3 halfword keeps only the top lane.
        case (offset)
            2'd0:    half_mask = 4'b1100;
            2'd1:    half_mask = 4'b1001;
            2'd2:    half_mask = 4'b0011;
            default: half_mask = 4'b0111;
        endcase
    end

    always_comb begin
        case (dtype)
            `MEM_BYTE,
            `MEM_BYTE_U:  lane_mask = byte_mask;
            `MEM_HWORD,
            `MEM_HWORD_U: lane_mask = half_mask;
            `MEM_WORD:    lane_mask = '0;
            default:      lane_mask = '1;
        endcase
    end

    assign lane_mask_o   = lane_mask;
    assign load_signed_o = ~dtype[2];

    // words ignore the low address bits.
    assign wr_shift = (dtype == `MEM_WORD) ? 2'd0 : offset;
    assign wr_word  = ex_mem_i.dm_data << {wr_shift, 3'b000};

    always_comb begin
        for (int n = 0; n < `LANES; n++) begin
            lane_req_o[n].word_idx = word_idx;
            lane_req_o[n].wr_en    = ex_mem_i.dm_wr & ~lane_mask[n];
            lane_req_o[n].wr_byte  = wr_word[8*n +: 8];
        end
    end

endmodule

// ==== logic/dmem_byte_lane.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module dmem_byte_lane #(
    parameter int WORDS_LOG2 = `DMEM_WORDS_LOG2
) (
    input  logic               clk,
    input  mem_pkg::lane_req_t req_i,
    output logic [7:0]         rd_byte_o
);

    logic [WORDS_LOG2-1:0] idx;
    logic [7:0]            mem_q [2**WORDS_LOG2];

    assign idx = WORDS_LOG2'(req_i.word_idx);

    always_ff @(posedge clk) begin
        if (req_i.wr_en) begin
            mem_q[idx] <= req_i.wr_byte;
        end
    end

    // read is asynchronous.
    assign rd_byte_o = mem_q[idx];

endmodule

// ==== logic/mem_pkg.sv ====
`include "mem_defs.svh"

package mem_pkg;

    typedef logic [`DATA_BITS-1:0]       data_t;
    typedef logic [`ADDR_BITS-1:0]       addr_t;
    typedef logic [`REG_BITS-1:0]        reg_addr_t;
    typedef logic [`TYPE_BITS-1:0]       mem_type_t;
    // active low, bit n covers byte n.
    typedef logic [`LANES-1:0]           lane_mask_t;
    typedef logic [`DMEM_WORDS_LOG2-1:0] word_idx_t;

    // record from the execute stage.
    typedef struct packed {
        data_t     aluout;
        data_t     pc2reg;
        logic      rd_src;
        data_t     dm_data;
        reg_addr_t rd_addr;
        logic      reg_wr;
        logic      dm_rd;
        logic      dm_wr;
        logic      dm2reg;
        mem_type_t datatype;
    } ex_mem_t;

    // record handed to writeback.
    typedef struct packed {
        data_t     rd_data;
        reg_addr_t rd_addr;
        logic      reg_wr;
        data_t     dm_out;
        logic      dm2reg;
    } mem_wb_t;

    // request to one byte lane.
    typedef struct packed {
        word_idx_t  word_idx;
        logic       wr_en;
        logic [7:0] wr_byte;
    } lane_req_t;

endpackage

// ==== logic/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// datapath widths.
`define DATA_BITS       32
`define ADDR_BITS       32
`define REG_BITS        5

// data memory organisation.
`define LANES           4
`define DMEM_WORDS_LOG2 10

// access-type codes, bit 2 set means unsigned.
`define TYPE_BITS       3
`define MEM_BYTE        3'b000
`define MEM_HWORD       3'b001
`define MEM_WORD        3'b010
`define MEM_BYTE_U      3'b100
`define MEM_HWORD_U     3'b101

`endif
